// File: design/qeciphy_pkg.sv
// Shared widths, control slot constants and FSM state types for the QEC PHY SERDES.
// Imported by the RTL modules and the testbench.
package qeciphy_pkg;

   // ==================================================
   // Datapath widths
   // ==================================================
   localparam int DATA_W = 64;  // Protocol word
   localparam int LANE_W = 32;  // Lane word, half a protocol word

   // ==================================================
   // Control slot
   // ==================================================
   // Upper half of the control slot, used for byte alignment
   // Aperiodic, so no rotation matches itself
   localparam logic [LANE_W-1:0] COMMA_WORD = 32'h5A3C_0F17;  // 16 ones

   // Lower half of the control slot, marks the frame boundary
   // Odd popcount, so it is never a rotation of the comma
   localparam logic [LANE_W-1:0] FAW_WORD = 32'hF628_D0E4;  // 15 ones

   // ==================================================
   // FSM states
   // ==================================================
   // Byte aligner
   typedef enum logic [2:0] {
      ALN_HUNT   = 3'd0,  // Scan a window for the comma
      ALN_SLIDE  = 3'd1,  // One-cycle slide request
      ALN_WAIT   = 3'd2,  // Lane busy after slide
      ALN_LOCKED = 3'd3,  // Two commas at the right distance
      ALN_FAIL   = 3'd4   // Out of slides, sticky until reset
   } aln_state_e;

   // Word aligner
   typedef enum logic {
      WA_SEARCH = 1'b0,  // Look for COMMA then FAW
      WA_LOCKED = 1'b1   // Pair phase fixed
   } wa_state_e;

endpackage

// File: design/qeciphy_tx_64b_to_32b.sv
// TX gearbox: takes one 64-bit word per slot and sends it as two 32-bit lane words.
// Every TX_PATTERN_LENGTH-th slot carries COMMA_WORD and FAW_WORD instead of data.
`timescale 1ns/1ps

module qeciphy_tx_64b_to_32b
   import qeciphy_pkg::*;
#(
   parameter int TX_PATTERN_LENGTH = 16  // Slots between control slots
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [DATA_W-1:0] tx_tdata_i,     // Sampled when tx_take_o is high
   output logic              tx_take_o,      // Data slot, phase 0
   output logic [LANE_W-1:0] tx_lane_word_o  // Registered lane word
);

   localparam int SLOT_W = (TX_PATTERN_LENGTH > 1) ? $clog2(TX_PATTERN_LENGTH) : 1;

   logic              phase_q;    // 0 = upper half cycle
   logic [SLOT_W-1:0] slot_q;     // Slot index within the pattern
   logic              ctrl_slot;  // Slot 0 is the control slot
   logic [LANE_W-1:0] low_q;      // Lower half held for phase 1

   assign ctrl_slot = (slot_q == '0);
   assign tx_take_o = !phase_q && !ctrl_slot;  // Low during reset, slot 0 is control

   // ==================================================
   // Phase and slot counters
   // ==================================================
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         phase_q <= 1'b0;
         slot_q  <= '0;
      end else begin
         phase_q <= ~phase_q;
         if (phase_q) begin  // Slot ends after the lower half
            if (slot_q == SLOT_W'(TX_PATTERN_LENGTH - 1)) slot_q <= '0;
            else slot_q <= slot_q + 1'b1;
         end
      end
   end

   // ==================================================
   // Half-word shifter
   // ==================================================
   always_ff @(posedge clk_i) begin
      if (!phase_q) begin
         if (ctrl_slot) begin
            tx_lane_word_o <= COMMA_WORD;  // Comma first
            low_q          <= FAW_WORD;
         end else begin
            tx_lane_word_o <= tx_tdata_i[DATA_W-1 -: LANE_W];  // Upper half first
            low_q          <= tx_tdata_i[LANE_W-1:0];
         end
      end else begin
         tx_lane_word_o <= low_q;
      end
   end

   // Source sees at most one take per slot
   a_take_spaced : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_take_o |=> !tx_take_o);

endmodule

// File: design/qeciphy_lane_model.sv
// Behavioral serial lane: delays the bit stream by a slip offset, 2 cycles latency.
// A slide pulse while idle moves the offset by one bit, then the lane is busy 4 cycles.
`timescale 1ns/1ps

module qeciphy_lane_model
   import qeciphy_pkg::*;
#(
   parameter int unsigned LANE_SLIP = 13  // Initial bit offset, 0..31
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [LANE_W-1:0] lane_word_i,  // From the TX gearbox
   input  logic              slide_i,      // One-cycle slide request
   output logic [LANE_W-1:0] lane_word_o,  // Slipped word
   output logic              slide_rdy_o   // Lane idle
);

   localparam int OFS_W  = $clog2(LANE_W);
   localparam int BUSY_W = 3;
   localparam logic [BUSY_W-1:0] BUSY_CYCLES = 3'd4;  // Slide settling time

   logic [LANE_W-1:0]   cur_q;     // Newest word
   logic [LANE_W-1:0]   prev_q;    // Word before it
   logic [2*LANE_W-1:0] hist;      // Two-word bit history, oldest bit at the top
   logic [OFS_W-1:0]    offset_q;  // Bits of extra delay
   logic [BUSY_W-1:0]   busy_q;    // Cycles left until idle

   // History shift, payload only
   always_ff @(posedge clk_i) begin
      cur_q  <= lane_word_i;
      prev_q <= cur_q;
   end

   assign hist = {prev_q, cur_q};

   // Offset 0 gives prev_q, each step pulls one bit later
   assign lane_word_o = hist[(2*LANE_W-1) - offset_q -: LANE_W];

   // ==================================================
   // Slide control
   // ==================================================
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         offset_q <= OFS_W'(LANE_SLIP);
         busy_q   <= '0;
      end else if (slide_i && slide_rdy_o) begin
         offset_q <= offset_q + 1'b1;  // Wraps mod 32
         busy_q   <= BUSY_CYCLES;
      end else if (busy_q != '0) begin
         busy_q <= busy_q - 1'b1;
      end
   end

   assign slide_rdy_o = (busy_q == '0);

   // Aligner must wait for the lane to settle
   a_slide_when_rdy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slide_i |-> slide_rdy_o);

endmodule

// File: design/qeciphy_rx_bytealigner.sv
// RX stage 1: hunts for COMMA_WORD in the lane stream and slides the lane until it
// sees two commas one pattern apart. Gives up after MAX_SLIDES slides.
`timescale 1ns/1ps

module qeciphy_rx_bytealigner
   import qeciphy_pkg::*;
#(
   parameter int TX_PATTERN_LENGTH = 16,  // Slots between control slots
   parameter int MAX_SLIDES        = 40   // Slides before giving up
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [LANE_W-1:0] lane_word_i,
   input  logic              slide_rdy_i,   // Lane idle
   output logic              slide_o,       // One-cycle slide pulse
   output logic              align_done_o,  // Byte aligned
   output logic              align_fail_o   // Sticky failure
);

   localparam int WIN_LEN   = 2*TX_PATTERN_LENGTH + 2;  // Words per hunt window
   localparam int COMMA_GAP = 2*TX_PATTERN_LENGTH;      // Lane words between commas
   localparam int WIN_W     = $clog2(WIN_LEN);
   localparam int GAP_W     = $clog2(COMMA_GAP + 1);
   localparam int SLD_W     = $clog2(MAX_SLIDES + 1);

   aln_state_e        state_q;
   logic [WIN_W-1:0]  win_cnt_q;    // Position in window
   logic [GAP_W-1:0]  gap_cnt_q;    // Words since last comma
   logic              seen_q;       // A comma is being tracked
   logic              win_hit_q;    // Comma in this window
   logic [SLD_W-1:0]  slide_cnt_q;  // Slides so far
   logic              comma_det;
   logic              pair_ok;      // Second comma at the expected distance
   logic              win_end;

   assign comma_det = (lane_word_i == COMMA_WORD);
   assign pair_ok   = comma_det && seen_q && (gap_cnt_q == GAP_W'(COMMA_GAP));
   assign win_end   = (win_cnt_q == WIN_W'(WIN_LEN - 1));

   // ==================================================
   // Alignment FSM
   // ==================================================
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= ALN_HUNT;
         win_cnt_q   <= '0;
         gap_cnt_q   <= '0;
         seen_q      <= 1'b0;
         win_hit_q   <= 1'b0;
         slide_cnt_q <= '0;
      end else begin
         case (state_q)
            ALN_HUNT: begin
               win_cnt_q <= win_cnt_q + 1'b1;
               // Track the distance from the last comma
               if (comma_det) begin
                  seen_q    <= 1'b1;
                  gap_cnt_q <= GAP_W'(1);
                  win_hit_q <= 1'b1;
               end else if (seen_q) begin
                  if (gap_cnt_q == GAP_W'(COMMA_GAP)) seen_q <= 1'b0;  // Missed one
                  else gap_cnt_q <= gap_cnt_q + 1'b1;
               end
               if (pair_ok) begin
                  state_q <= ALN_LOCKED;
               end else if (win_end) begin
                  win_cnt_q <= '0;
                  win_hit_q <= 1'b0;
                  // A comma in the window means keep hunting here
                  if (!(win_hit_q || comma_det)) begin
                     if (slide_cnt_q == SLD_W'(MAX_SLIDES)) state_q <= ALN_FAIL;
                     else state_q <= ALN_SLIDE;
                  end
               end
            end
            ALN_SLIDE: begin
               slide_cnt_q <= slide_cnt_q + 1'b1;
               state_q     <= ALN_WAIT;  // Lane drops rdy next cycle
            end
            ALN_WAIT: begin
               if (slide_rdy_i) begin  // Fresh window at the new offset
                  state_q   <= ALN_HUNT;
                  win_cnt_q <= '0;
                  win_hit_q <= 1'b0;
                  seen_q    <= 1'b0;
               end
            end
            ALN_LOCKED: state_q <= ALN_LOCKED;  // Held until reset
            ALN_FAIL:   state_q <= ALN_FAIL;
            default:    state_q <= ALN_HUNT;
         endcase
      end
   end

   assign slide_o      = (state_q == ALN_SLIDE);
   assign align_done_o = (state_q == ALN_LOCKED);
   assign align_fail_o = (state_q == ALN_FAIL);

   a_done_xor_fail : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(align_done_o && align_fail_o));

endmodule

// File: design/qeciphy_rx_32b_to_64b.sv
// RX stage 2: finds the COMMA/FAW pair to fix the half-word phase, then rebuilds
// 64-bit words. Control pairs are dropped; valid_o marks each data word.
`timescale 1ns/1ps

module qeciphy_rx_32b_to_64b
   import qeciphy_pkg::*;
(
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              byte_aligned_i,  // Releases the FSM
   input  logic [LANE_W-1:0] lane_word_i,     // Byte-aligned lane word
   output logic [DATA_W-1:0] tdata_64b_o,
   output logic              valid_o,         // One cycle per data word
   output logic              aligned_o        // Pair phase found
);

   wa_state_e         state_q;
   logic              wa_rst_n;     // Held until byte alignment
   logic [LANE_W-1:0] prev_word_q;  // Previous lane word
   logic              pair_ph_q;    // 1 = current word is the lower half
   logic              ctrl_pair;

   assign wa_rst_n  = rst_n_i & byte_aligned_i;
   assign ctrl_pair = (prev_word_q == COMMA_WORD) && (lane_word_i == FAW_WORD);

   always_ff @(posedge clk_i) begin
      prev_word_q <= lane_word_i;
   end

   // ==================================================
   // Word alignment FSM
   // ==================================================
   always_ff @(posedge clk_i) begin
      if (!wa_rst_n) begin
         state_q   <= WA_SEARCH;
         pair_ph_q <= 1'b0;
         valid_o   <= 1'b0;
      end else begin
         valid_o <= 1'b0;
         case (state_q)
            WA_SEARCH: begin
               if (ctrl_pair) begin  // FAW closes a pair
                  state_q   <= WA_LOCKED;
                  pair_ph_q <= 1'b0;  // Next word is an upper half
               end
            end
            WA_LOCKED: begin
               pair_ph_q <= ~pair_ph_q;
               if (pair_ph_q && !ctrl_pair) valid_o <= 1'b1;  // Drop control pairs
            end
            default: state_q <= WA_SEARCH;
         endcase
      end
   end

   // Assemble on the lower half, upper half came first
   always_ff @(posedge clk_i) begin
      if (pair_ph_q) tdata_64b_o <= {prev_word_q, lane_word_i};
   end

   assign aligned_o = (state_q == WA_LOCKED);

   // No output word before both alignment stages are done
   a_valid_aligned : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_o |-> (aligned_o && byte_aligned_i));

endmodule

// File: design/qeciphy_serdes.sv
// Top level of the QEC PHY SERDES datapath: TX gearbox, lane model and RX aligners.
// Single clock at the lane word rate; parameters are passed down from here.
`timescale 1ns/1ps

module qeciphy_serdes
   import qeciphy_pkg::*;
#(
   parameter int TX_PATTERN_LENGTH = 16,  // Control slot period in slots
   parameter int LANE_SLIP         = 13,  // Initial lane bit offset
   parameter int MAX_SLIDES        = 40   // Byte aligner slide budget
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [DATA_W-1:0] tx_tdata_i,
   output logic              tx_take_o,
   output logic [DATA_W-1:0] rx_tdata_o,
   output logic              rx_valid_o,
   output logic              rx_byte_aligned_o,
   output logic              rx_align_fail_o,
   output logic              rx_datapath_aligned_o
);

   logic [LANE_W-1:0] tx_lane_word;  // TX gearbox to lane
   logic [LANE_W-1:0] rx_lane_word;  // Lane to both aligners
   logic              slide;
   logic              slide_rdy;

   // ==================================================
   // TX and lane
   // ==================================================
   qeciphy_tx_64b_to_32b #(
      .TX_PATTERN_LENGTH(TX_PATTERN_LENGTH)
   ) i_tx_64b_to_32b (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .tx_tdata_i    (tx_tdata_i),
      .tx_take_o     (tx_take_o),
      .tx_lane_word_o(tx_lane_word)
   );

   qeciphy_lane_model #(
      .LANE_SLIP(LANE_SLIP)
   ) i_lane_model (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .lane_word_i(tx_lane_word),
      .slide_i    (slide),
      .lane_word_o(rx_lane_word),
      .slide_rdy_o(slide_rdy)
   );

   // ==================================================
   // RX alignment
   // ==================================================
   qeciphy_rx_bytealigner #(
      .TX_PATTERN_LENGTH(TX_PATTERN_LENGTH),
      .MAX_SLIDES       (MAX_SLIDES)
   ) i_rx_bytealigner (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .lane_word_i (rx_lane_word),
      .slide_rdy_i (slide_rdy),
      .slide_o     (slide),
      .align_done_o(rx_byte_aligned_o),  // Also releases the word aligner
      .align_fail_o(rx_align_fail_o)
   );

   qeciphy_rx_32b_to_64b i_rx_32b_to_64b (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .byte_aligned_i(rx_byte_aligned_o),
      .lane_word_i   (rx_lane_word),
      .tdata_64b_o   (rx_tdata_o),
      .valid_o       (rx_valid_o),
      .aligned_o     (rx_datapath_aligned_o)
   );

endmodule

// File: tests/qeciphy_checker.sv
// Checker for the SERDES testbench that models the sent word stream and compares RX words.
// Also watches the take pattern, alignment status and reset values and counts all errors.
`timescale 1ns/1ps

module qeciphy_checker
   import qeciphy_pkg::*;
#(
   parameter int TX_PATTERN_LENGTH = 16  // Control slot period in slots
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [DATA_W-1:0] tx_tdata_i,
   input  logic              tx_take_i,
   input  logic [DATA_W-1:0] rx_tdata_i,
   input  logic              rx_valid_i,
   input  logic              byte_aligned_i,
   input  logic              align_fail_i,
   input  logic              dp_aligned_i,
   input  logic              end_i,           // Run the end-of-test checks
   output int                mismatch_cnt_o,
   output int                error_cnt_o,
   output int                words_o,         // RX words seen
   output logic              done_o
);

   localparam int WIN_CYC     = 2*TX_PATTERN_LENGTH;  // Cycles in one pattern
   localparam int MATCH_DEPTH = 64;                   // Search depth for the first word

   logic [DATA_W-1:0]  exp_q[$];           // Sent words not yet received
   logic [WIN_CYC-1:0] take_hist  = '0;    // Take history with the newest at bit 0
   logic [1:0]         rst_seen_q = 2'b0;  // Reset seen at the last two edges
   logic               synced     = 1'b0;  // First RX word found in the queue
   int                 run_cyc    = 0;     // Cycles since reset release
   aln_state_e         aln_view   = ALN_HUNT;

   initial begin
      mismatch_cnt_o = 0;
      error_cnt_o    = 0;
      words_o        = 0;
      done_o         = 1'b0;
   end

   task automatic count_error(input string msg);
      error_cnt_o = error_cnt_o + 1;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   task automatic show_mismatch(input string msg);
      mismatch_cnt_o = mismatch_cnt_o + 1;
      $display("MISMATCH at %0t: %s", $time, msg);
   endtask

   always @(posedge clk_i) begin : watch
      logic [WIN_CYC-1:0] win;
      logic [DATA_W-1:0]  exp_word;
      aln_state_e         aln_now;
      int                 hit_idx;

      // Outputs settle one edge into reset and stay low through the first cycle after it
      if ((rst_seen_q != 2'b0) && ({tx_take_i, rx_valid_i, byte_aligned_i, align_fail_i,
                                    dp_aligned_i} !== 5'b0))
         count_error("an output was not low during or right after reset");
      rst_seen_q = {rst_seen_q[0], !rst_n_i};

      if (!rst_n_i) begin
         run_cyc   = 0;
         take_hist = '0;
      end else begin
         // ==================================================
         // Take pattern
         // ==================================================
         win = {take_hist[WIN_CYC-2:0], tx_take_i};
         if (tx_take_i && take_hist[0]) count_error("tx_take_o high in two adjacent cycles");
         if (run_cyc >= WIN_CYC-1 && $countones(win) != TX_PATTERN_LENGTH-1)
            count_error($sformatf("%0d takes within %0d slots", $countones(win),
                                  TX_PATTERN_LENGTH));
         take_hist = win;
         run_cyc   = run_cyc + 1;

         // Status seen from the ports
         aln_now = align_fail_i ? ALN_FAIL : (byte_aligned_i ? ALN_LOCKED : ALN_HUNT);
         if (aln_now != aln_view) begin
            $display("%0t: byte aligner now %s", $time, aln_now.name());
            if (aln_now == ALN_FAIL) count_error("byte aligner ran out of slides");
            aln_view = aln_now;
         end
         if (dp_aligned_i && !byte_aligned_i) count_error("word aligned before byte aligned");
         if (rx_valid_i && !dp_aligned_i) count_error("rx_valid_o pulsed before alignment");

         // ==================================================
         // Stream model
         // ==================================================
         if (tx_take_i) begin
            exp_q.push_back(tx_tdata_i);
            while (!synced && exp_q.size() > MATCH_DEPTH) exp_word = exp_q.pop_front();
         end
         if (rx_valid_i) begin
            words_o = words_o + 1;
            if (rx_tdata_i == {COMMA_WORD, FAW_WORD}) begin
               count_error("control pair reached rx_tdata_o");
            end else if (!synced) begin
               hit_idx = -1;
               for (int i = 0; i < exp_q.size(); i++)
                  if (hit_idx < 0 && exp_q[i] == rx_tdata_i) hit_idx = i;
               if (hit_idx < 0) begin
                  show_mismatch($sformatf("first word %h not among recent sent words",
                                          rx_tdata_i));
               end else begin
                  repeat (hit_idx + 1) exp_word = exp_q.pop_front();  // Older words lost to alignment
                  synced = 1'b1;
               end
            end else if (exp_q.size() == 0) begin
               count_error("word received with nothing left to compare");
            end else begin
               exp_word = exp_q.pop_front();
               if (rx_tdata_i !== exp_word)
                  show_mismatch($sformatf("rx_tdata_o %h, expected %h", rx_tdata_i, exp_word));
            end
         end
      end

      // End of run allows a few words still in flight
      if (end_i && !done_o) begin
         if (!synced) count_error("no data word ever reached the RX output");
         if (exp_q.size() >= 4)
            count_error($sformatf("%0d sent words never arrived", exp_q.size()));
         done_o = 1'b1;
      end
   end

endmodule

// File: tests/tb_qeciphy_serdes.sv
// Testbench for the QEC PHY SERDES: drives random 64-bit words, the checker compares
// the RX output. Runs a fixed number of cycles after reset, then prints the report.
`timescale 1ns/1ps

module tb_qeciphy_serdes
   import qeciphy_pkg::*;
();

   localparam int TX_PATTERN_LENGTH = 16;
   localparam int LANE_SLIP         = 13;
   localparam int MAX_SLIDES        = 40;
   localparam int RUN_CYCLES        = 3000;  // Cycles after reset release
   localparam int ALIGN_TIMEOUT     = 2000;  // Byte alignment budget
   localparam int DONE_TIMEOUT      = 8;     // Checker end-of-run budget

   logic              clk;
   logic              rst_n;
   logic [DATA_W-1:0] tx_tdata;
   logic              tx_take;
   logic [DATA_W-1:0] rx_tdata;
   logic              rx_valid;
   logic              rx_byte_aligned;
   logic              rx_align_fail;
   logic              rx_dp_aligned;
   logic              end_req;
   logic              chk_done;
   int                mismatch_cnt;
   int                error_cnt;
   int                word_cnt;
   int                seed = 32'h35d149b0;

   // ==================================================
   // Clock and stimulus
   // ==================================================
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns period
   end

   // True if w is the comma at any bit rotation
   function automatic logic is_comma_rotation(input logic [LANE_W-1:0] w);
      logic [LANE_W-1:0] rot;
      rot = COMMA_WORD;
      for (int k = 0; k < LANE_W; k++) begin
         if (w == rot) return 1'b1;
         rot = {rot[LANE_W-2:0], rot[LANE_W-1]};
      end
      return 1'b0;
   endfunction

   task automatic draw_clean_word(output logic [DATA_W-1:0] word);
      logic [LANE_W-1:0] hi;
      logic [LANE_W-1:0] lo;
      hi = $random(seed);
      lo = $random(seed);
      while (is_comma_rotation(hi) || is_comma_rotation(lo)) begin  // Keep commas out of data
         hi = $random(seed);
         lo = $random(seed);
      end
      word = {hi, lo};
   endtask

   always @(negedge clk) draw_clean_word(tx_tdata);  // New word every cycle

   qeciphy_serdes #(
      .TX_PATTERN_LENGTH(TX_PATTERN_LENGTH),
      .LANE_SLIP        (LANE_SLIP),
      .MAX_SLIDES       (MAX_SLIDES)
   ) dut0 (
      .clk_i                (clk),
      .rst_n_i              (rst_n),
      .tx_tdata_i           (tx_tdata),
      .tx_take_o            (tx_take),
      .rx_tdata_o           (rx_tdata),
      .rx_valid_o           (rx_valid),
      .rx_byte_aligned_o    (rx_byte_aligned),
      .rx_align_fail_o      (rx_align_fail),
      .rx_datapath_aligned_o(rx_dp_aligned)
   );

   qeciphy_checker #(
      .TX_PATTERN_LENGTH(TX_PATTERN_LENGTH)
   ) i_checker (
      .clk_i(clk), .rst_n_i(rst_n), .tx_tdata_i(tx_tdata), .tx_take_i(tx_take),
      .rx_tdata_i(rx_tdata), .rx_valid_i(rx_valid), .byte_aligned_i(rx_byte_aligned),
      .align_fail_i(rx_align_fail), .dp_aligned_i(rx_dp_aligned), .end_i(end_req),
      .mismatch_cnt_o(mismatch_cnt), .error_cnt_o(error_cnt), .words_o(word_cnt),
      .done_o(chk_done)
   );

   // ==================================================
   // Run control
   // ==================================================
   initial begin : run
      int cyc;
      rst_n    = 1'b0;
      tx_tdata = '0;
      end_req  = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      cyc   = 0;
      while (!rx_byte_aligned && cyc < ALIGN_TIMEOUT) begin  // Sampled mid-cycle
         @(negedge clk);
         cyc = cyc + 1;
      end
      if (!rx_byte_aligned) begin
         $display("Byte alignment never came within %0d cycles", ALIGN_TIMEOUT);
         $display("TEST FAILED");
         $finish;
      end else begin
         while (cyc < RUN_CYCLES) begin
            @(negedge clk);
            cyc = cyc + 1;
         end
         end_req = 1'b1;
         cyc     = 0;
         while (!chk_done && cyc < DONE_TIMEOUT) begin
            @(negedge clk);
            cyc = cyc + 1;
         end
         if (!chk_done) begin
            $display("Checker never finished its end-of-run checks");
            $display("TEST FAILED");
         end else begin
            $display("Errors: %0d mismatches, %0d other, %0d words received",
                     mismatch_cnt, error_cnt, word_cnt);
            if (mismatch_cnt == 0 && error_cnt == 0) $display("TEST PASSED");
            else $display("TEST FAILED");
         end
         $finish;
      end
   end

endmodule

// File: project.f
design/qeciphy_pkg.sv
design/qeciphy_tx_64b_to_32b.sv
design/qeciphy_lane_model.sv
design/qeciphy_rx_bytealigner.sv
design/qeciphy_rx_32b_to_64b.sv
design/qeciphy_serdes.sv
tests/qeciphy_checker.sv
tests/tb_qeciphy_serdes.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_qeciphy_serdes
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
